//--- Bender.yml
package:
  name: c16_memory

sources:
  - hdl/c16_mem_pkg.sv
  - hdl/download_fifo.sv
  - hdl/image_loader.sv
  - hdl/main_ram.sv
  - hdl/memory_map.sv
  - hdl/rom_banks.sv
  - hdl/c16_memory_top.sv
  - target: test
    files:
      - verification/c16_memory_props.sv
      - verification/tb_c16_memory.sv

//--- build.f
hdl/c16_mem_pkg.sv
hdl/download_fifo.sv
hdl/image_loader.sv
hdl/main_ram.sv
hdl/memory_map.sv
hdl/rom_banks.sv
hdl/c16_memory_top.sv
verification/c16_memory_props.sv
verification/tb_c16_memory.sv

//--- hdl/c16_mem_pkg.sv
`default_nettype none

package c16_mem_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	localparam int CPU_AW    = 16;
	localparam int ROM_AW    = 14;
	// Upper three bits pick the slot, lower bits the bank offset
	localparam int DL_AW     = 17;
	localparam int NUM_BANKS = 6;

	typedef logic [7:0] byte_t;

	////////////////////////////////////////////////////////////
	// Download kinds, bank register halves and bank names
	////////////////////////////////////////////////////////////

	typedef enum logic [7:0] {
		LOAD_PRG = 8'h01,
		LOAD_ROM = 8'h03,
		LOAD_CRT = 8'h81
	} load_kind_e;

	typedef enum logic [1:0] {
		ROM_INTERNAL = 2'd0,
		ROM_CART     = 2'd1,
		ROM_FUNC     = 2'd2,
		ROM_NONE     = 2'd3
	} rom_sel_e;

	typedef enum logic [2:0] {
		BANK_KERNAL,
		BANK_BASIC,
		BANK_FUNC_LO,
		BANK_FUNC_HI,
		BANK_CART_LO,
		BANK_CART_HI
	} bank_e;

	// Firmware slots
	localparam logic [2:0] SLOT_KERNAL  = 3'd1;
	localparam logic [2:0] SLOT_BASIC   = 3'd2;
	localparam logic [2:0] SLOT_FUNC_LO = 3'd3;
	localparam logic [2:0] SLOT_FUNC_HI = 3'd4;

	// Cartridge slots
	localparam logic [2:0] SLOT_CART_LO = 3'd0;
	localparam logic [2:0] SLOT_CART_HI = 3'd1;

	// BASIC pointers in zero page, low byte first in each pair
	localparam logic [7:0] PRG_PTR_ADDRS [8] = '{
		8'h2D, 8'h2E, 8'h2F, 8'h30, 8'h31, 8'h32, 8'h9D, 8'h9E
	};

	localparam logic [11:0] BANK_REG_PAGE = 12'hFDD;
	localparam logic [7:0]  KERNAL_PAGE   = 8'hFC;

endpackage

`default_nettype wire

//--- hdl/c16_memory_top.sv
`timescale 1ns/1ps
`default_nettype none

module c16_memory_top #(
	parameter int DL_FIFO_DEPTH = 4
) (
	input  wire                               clk_sys,
	input  wire                               reset,
	input  wire                               plus4_i,

	// Host download
	input  wire                               dl_active_i,
	input  wire c16_mem_pkg::load_kind_e      dl_kind_i,
	input  wire                               dl_valid_i,
	input  wire [c16_mem_pkg::DL_AW-1:0]      dl_addr_i,
	input  wire c16_mem_pkg::byte_t           dl_data_i,
	output logic                              dl_credit_o,

	// CPU bus
	input  wire [c16_mem_pkg::CPU_AW-1:0]     cpu_addr_i,
	input  wire c16_mem_pkg::byte_t           cpu_dout_i,
	input  wire                               cpu_rnw_i,
	input  wire                               cs_ram_i,
	input  wire                               cs0_i,
	input  wire                               cs1_i,
	input  wire                               cs_io_i,
	output c16_mem_pkg::byte_t                cpu_din_o
);

	logic                              fifo_empty;
	logic                              fifo_pop;
	logic [c16_mem_pkg::DL_AW-1:0]     fifo_head_addr;
	c16_mem_pkg::byte_t                fifo_head_data;

	logic                              ld_ram_we;
	logic [c16_mem_pkg::CPU_AW-1:0]    ld_ram_addr;
	c16_mem_pkg::byte_t                ld_ram_data;

	logic                              rom_we;
	c16_mem_pkg::bank_e                rom_bank;
	logic [c16_mem_pkg::ROM_AW-1:0]    rom_addr;
	c16_mem_pkg::byte_t                rom_data;

	logic [c16_mem_pkg::NUM_BANKS-1:0] bank_sel;
	c16_mem_pkg::byte_t                ram_rd;
	c16_mem_pkg::byte_t                rom_rd;

	////////////////////////////////////////////////////////////
	// Download path
	////////////////////////////////////////////////////////////

	download_fifo #(
		.DL_FIFO_DEPTH(DL_FIFO_DEPTH)
	) u_download_fifo (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.push_i      (dl_valid_i),
		.push_addr_i (dl_addr_i),
		.push_data_i (dl_data_i),
		.pop_i       (fifo_pop),
		.empty_o     (fifo_empty),
		.head_addr_o (fifo_head_addr),
		.head_data_o (fifo_head_data),
		.credit_o    (dl_credit_o)
	);

	image_loader u_image_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_kind_i   (dl_kind_i),
		.empty_i     (fifo_empty),
		.head_addr_i (fifo_head_addr),
		.head_data_i (fifo_head_data),
		.pop_o       (fifo_pop),
		.ram_we_o    (ld_ram_we),
		.ram_addr_o  (ld_ram_addr),
		.ram_data_o  (ld_ram_data),
		.rom_we_o    (rom_we),
		.rom_bank_o  (rom_bank),
		.rom_addr_o  (rom_addr),
		.rom_data_o  (rom_data)
	);

	////////////////////////////////////////////////////////////
	// Memories and decode
	////////////////////////////////////////////////////////////

	main_ram u_main_ram (
		.clk_sys    (clk_sys),
		.ld_we_i    (ld_ram_we),
		.ld_addr_i  (ld_ram_addr),
		.ld_data_i  (ld_ram_data),
		.cpu_addr_i (cpu_addr_i),
		.cpu_dout_i (cpu_dout_i),
		.cpu_rnw_i  (cpu_rnw_i),
		.cs_ram_i   (cs_ram_i),
		.rd_o       (ram_rd)
	);

	memory_map u_memory_map (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.plus4_i    (plus4_i),
		.cpu_addr_i (cpu_addr_i),
		.cpu_rnw_i  (cpu_rnw_i),
		.cs0_i      (cs0_i),
		.cs1_i      (cs1_i),
		.cs_io_i    (cs_io_i),
		.bank_sel_o (bank_sel)
	);

	rom_banks u_rom_banks (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.we_i       (rom_we),
		.bank_i     (rom_bank),
		.waddr_i    (rom_addr),
		.wdata_i    (rom_data),
		.cpu_addr_i (cpu_addr_i[c16_mem_pkg::ROM_AW-1:0]),
		.bank_sel_i (bank_sel),
		.rd_o       (rom_rd)
	);

	// Wired-AND read bus
	assign cpu_din_o = ram_rd & rom_rd;

endmodule

`default_nettype wire

//--- hdl/download_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module download_fifo #(
	parameter int DL_FIFO_DEPTH = 4
) (
	input  wire                               clk_sys,
	input  wire                               reset,
	input  wire                               push_i,
	input  wire [c16_mem_pkg::DL_AW-1:0]      push_addr_i,
	input  wire c16_mem_pkg::byte_t           push_data_i,
	input  wire                               pop_i,
	output logic                              empty_o,
	output logic [c16_mem_pkg::DL_AW-1:0]     head_addr_o,
	output c16_mem_pkg::byte_t                head_data_o,
	output logic                              credit_o
);

	localparam int PW = $clog2(DL_FIFO_DEPTH);

	logic [c16_mem_pkg::DL_AW-1:0] addr_mem [DL_FIFO_DEPTH];
	c16_mem_pkg::byte_t            data_mem [DL_FIFO_DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW:0]   count;
	logic          pop_ok;

	// A pop on an empty buffer is ignored
	assign pop_ok   = pop_i && !empty_o;
	assign empty_o  = (count == '0);
	assign credit_o = pop_ok;

	assign head_addr_o = addr_mem[rd_ptr];
	assign head_data_o = data_mem[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			// Host credits keep the count within depth
			case ({push_i, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push_i) begin
			addr_mem[wr_ptr] <= push_addr_i;
			data_mem[wr_ptr] <= push_data_i;
		end
	end

endmodule

`default_nettype wire

//--- hdl/image_loader.sv
`timescale 1ns/1ps
`default_nettype none

module image_loader (
	input  wire                                 clk_sys,
	input  wire                                 reset,
	input  wire                                 dl_active_i,
	input  wire c16_mem_pkg::load_kind_e        dl_kind_i,
	input  wire                                 empty_i,
	input  wire [c16_mem_pkg::DL_AW-1:0]        head_addr_i,
	input  wire c16_mem_pkg::byte_t             head_data_i,
	output logic                                pop_o,
	output logic                                ram_we_o,
	output logic [c16_mem_pkg::CPU_AW-1:0]      ram_addr_o,
	output c16_mem_pkg::byte_t                  ram_data_o,
	output logic                                rom_we_o,
	output c16_mem_pkg::bank_e                  rom_bank_o,
	output logic [c16_mem_pkg::ROM_AW-1:0]      rom_addr_o,
	output c16_mem_pkg::byte_t                  rom_data_o
);

	typedef enum logic [1:0] {
		IDLE,
		STREAM,
		PATCH
	} state_e;

	state_e                                            state;
	c16_mem_pkg::load_kind_e                           kind_q;
	logic [c16_mem_pkg::CPU_AW-1:0]                    prg_addr;
	logic [3:0]                                        patch_cnt;
	logic [c16_mem_pkg::DL_AW-c16_mem_pkg::ROM_AW-1:0] slot;
	logic                                              prg_body;
	logic                                              bank_hit;
	c16_mem_pkg::bank_e                                bank_map;

	// Bytes only leave the FIFO while streaming, so a patch stalls them
	assign pop_o    = (state == STREAM) && !empty_i;
	assign slot     = head_addr_i[c16_mem_pkg::DL_AW-1:c16_mem_pkg::ROM_AW];
	// Offsets 0 and 1 carry the load address
	assign prg_body = (head_addr_i[c16_mem_pkg::DL_AW-1:1] != '0);

	////////////////////////////////////////////////////////////
	// Slot to bank mapping
	////////////////////////////////////////////////////////////

	always_comb begin
		bank_hit = 1'b0;
		bank_map = c16_mem_pkg::BANK_KERNAL;
		if (kind_q == c16_mem_pkg::LOAD_ROM) begin
			bank_hit = 1'b1;
			case (slot)
				c16_mem_pkg::SLOT_KERNAL:  bank_map = c16_mem_pkg::BANK_KERNAL;
				c16_mem_pkg::SLOT_BASIC:   bank_map = c16_mem_pkg::BANK_BASIC;
				c16_mem_pkg::SLOT_FUNC_LO: bank_map = c16_mem_pkg::BANK_FUNC_LO;
				c16_mem_pkg::SLOT_FUNC_HI: bank_map = c16_mem_pkg::BANK_FUNC_HI;
				default:                   bank_hit = 1'b0;
			endcase
		end else if (kind_q == c16_mem_pkg::LOAD_CRT) begin
			bank_hit = 1'b1;
			case (slot)
				c16_mem_pkg::SLOT_CART_LO: bank_map = c16_mem_pkg::BANK_CART_LO;
				c16_mem_pkg::SLOT_CART_HI: bank_map = c16_mem_pkg::BANK_CART_HI;
				default:                   bank_hit = 1'b0;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// FSM and write strobes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= IDLE;
			patch_cnt <= '0;
			ram_we_o  <= 1'b0;
			rom_we_o  <= 1'b0;
		end else begin
			ram_we_o <= 1'b0;
			rom_we_o <= 1'b0;
			case (state)
				IDLE: begin
					if (dl_active_i)
						state <= STREAM;
				end
				STREAM: begin
					if (pop_o) begin
						ram_we_o <= (kind_q == c16_mem_pkg::LOAD_PRG) && prg_body;
						rom_we_o <= bank_hit;
					end
					// Download over and everything drained
					if (!dl_active_i && empty_i) begin
						state     <= (kind_q == c16_mem_pkg::LOAD_PRG) ? PATCH : IDLE;
						patch_cnt <= '0;
					end
				end
				PATCH: begin
					// One pointer byte every second cycle
					ram_we_o  <= !patch_cnt[0];
					patch_cnt <= patch_cnt + 1'b1;
					if (patch_cnt == 4'hF)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Address and data path
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (state == IDLE)
			kind_q <= dl_kind_i;

		if (pop_o) begin
			if (kind_q == c16_mem_pkg::LOAD_PRG) begin
				if (!prg_body) begin
					if (head_addr_i[0])
						prg_addr[15:8] <= head_data_i;
					else
						prg_addr[7:0] <= head_data_i;
				end else begin
					ram_addr_o <= prg_addr;
					ram_data_o <= head_data_i;
					prg_addr   <= prg_addr + 1'b1;
				end
			end
			rom_bank_o <= bank_map;
			rom_addr_o <= head_addr_i[c16_mem_pkg::ROM_AW-1:0];
			rom_data_o <= head_data_i;
		end

		// prg_addr now holds the end address
		if (state == PATCH) begin
			ram_addr_o <= {8'h00, c16_mem_pkg::PRG_PTR_ADDRS[patch_cnt[3:1]]};
			ram_data_o <= patch_cnt[1] ? prg_addr[15:8] : prg_addr[7:0];
		end
	end

endmodule

`default_nettype wire

//--- hdl/main_ram.sv
`timescale 1ns/1ps
`default_nettype none

module main_ram (
	input  wire                              clk_sys,
	input  wire                              ld_we_i,
	input  wire [c16_mem_pkg::CPU_AW-1:0]    ld_addr_i,
	input  wire c16_mem_pkg::byte_t          ld_data_i,
	input  wire [c16_mem_pkg::CPU_AW-1:0]    cpu_addr_i,
	input  wire c16_mem_pkg::byte_t          cpu_dout_i,
	input  wire                              cpu_rnw_i,
	input  wire                              cs_ram_i,
	output c16_mem_pkg::byte_t               rd_o
);

	c16_mem_pkg::byte_t mem [2**c16_mem_pkg::CPU_AW];

	logic cs_q;
	logic cpu_we;

	// Write strobe on release of the chip select
	always_ff @(posedge clk_sys) begin
		cs_q   <= cs_ram_i;
		cpu_we <= !cs_q && cs_ram_i && !cpu_rnw_i;
	end

	// Loader port and CPU port
	always_ff @(posedge clk_sys) begin
		if (ld_we_i)
			mem[ld_addr_i] <= ld_data_i;
		if (cpu_we)
			mem[cpu_addr_i] <= cpu_dout_i;
		// Idle bus reads as all ones
		rd_o <= cs_ram_i ? 8'hFF : mem[cpu_addr_i];
	end

endmodule

`default_nettype wire

//--- hdl/memory_map.sv
`timescale 1ns/1ps
`default_nettype none

module memory_map (
	input  wire                                 clk_sys,
	input  wire                                 reset,
	input  wire                                 plus4_i,
	input  wire [c16_mem_pkg::CPU_AW-1:0]       cpu_addr_i,
	input  wire                                 cpu_rnw_i,
	input  wire                                 cs0_i,
	input  wire                                 cs1_i,
	input  wire                                 cs_io_i,
	output logic [c16_mem_pkg::NUM_BANKS-1:0]   bank_sel_o
);

	logic                  plus4_q;
	logic                  cs_io_q;
	logic                  bank_wr;
	logic                  kern_page;
	c16_mem_pkg::rom_sel_e rom_hi;
	c16_mem_pkg::rom_sel_e rom_lo;

	// Bank register write on release of the I/O select in page FDD
	assign bank_wr = plus4_q && !cs_io_q && cs_io_i && !cpu_rnw_i &&
		(cpu_addr_i[c16_mem_pkg::CPU_AW-1:4] == c16_mem_pkg::BANK_REG_PAGE);

	assign kern_page = (cpu_addr_i[c16_mem_pkg::CPU_AW-1:8] == c16_mem_pkg::KERNAL_PAGE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			// Model is taken over while in reset
			plus4_q <= plus4_i;
			cs_io_q <= 1'b1;
			rom_hi  <= c16_mem_pkg::ROM_INTERNAL;
			rom_lo  <= c16_mem_pkg::ROM_INTERNAL;
		end else begin
			cs_io_q <= cs_io_i;
			if (bank_wr) begin
				rom_hi <= c16_mem_pkg::rom_sel_e'(cpu_addr_i[3:2]);
				rom_lo <= c16_mem_pkg::rom_sel_e'(cpu_addr_i[1:0]);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read selects
	////////////////////////////////////////////////////////////

	always_comb begin
		bank_sel_o = '0;

		// Low ROM window
		if (!cs0_i) begin
			bank_sel_o[c16_mem_pkg::BANK_BASIC]   = (rom_lo == c16_mem_pkg::ROM_INTERNAL);
			bank_sel_o[c16_mem_pkg::BANK_FUNC_LO] = (rom_lo == c16_mem_pkg::ROM_FUNC);
			bank_sel_o[c16_mem_pkg::BANK_CART_LO] = (rom_lo == c16_mem_pkg::ROM_CART);
		end

		// High ROM window, FCxx stays on the kernal
		if (!cs1_i) begin
			bank_sel_o[c16_mem_pkg::BANK_KERNAL] =
				kern_page || (rom_hi == c16_mem_pkg::ROM_INTERNAL);
			bank_sel_o[c16_mem_pkg::BANK_FUNC_HI] =
				!kern_page && (rom_hi == c16_mem_pkg::ROM_FUNC);
			bank_sel_o[c16_mem_pkg::BANK_CART_HI] =
				!kern_page && (rom_hi == c16_mem_pkg::ROM_CART);
		end
	end

endmodule

`default_nettype wire

//--- hdl/rom_banks.sv
`timescale 1ns/1ps
`default_nettype none

module rom_banks (
	input  wire                                 clk_sys,
	input  wire                                 reset,
	input  wire                                 we_i,
	input  wire c16_mem_pkg::bank_e             bank_i,
	input  wire [c16_mem_pkg::ROM_AW-1:0]       waddr_i,
	input  wire c16_mem_pkg::byte_t             wdata_i,
	input  wire [c16_mem_pkg::ROM_AW-1:0]       cpu_addr_i,
	input  wire [c16_mem_pkg::NUM_BANKS-1:0]    bank_sel_i,
	output c16_mem_pkg::byte_t                  rd_o
);

	logic                              cart_lo_loaded;
	logic                              cart_hi_loaded;
	logic [c16_mem_pkg::NUM_BANKS-1:0] bank_ok;
	wire  [7:0]                        bank_q [c16_mem_pkg::NUM_BANKS];

	////////////////////////////////////////////////////////////
	// Cartridge loaded flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_lo_loaded <= 1'b0;
			cart_hi_loaded <= 1'b0;
		end else if (we_i) begin
			if (bank_i == c16_mem_pkg::BANK_CART_LO)
				cart_lo_loaded <= 1'b1;
			if (bank_i == c16_mem_pkg::BANK_CART_HI)
				cart_hi_loaded <= 1'b1;
		end
	end

	// Firmware banks always count as present
	always_comb begin
		bank_ok = '1;
		bank_ok[c16_mem_pkg::BANK_CART_LO] = cart_lo_loaded;
		bank_ok[c16_mem_pkg::BANK_CART_HI] = cart_hi_loaded;
	end

	////////////////////////////////////////////////////////////
	// Bank arrays
	////////////////////////////////////////////////////////////

	for (genvar b = 0; b < c16_mem_pkg::NUM_BANKS; b++) begin : g_bank
		c16_mem_pkg::byte_t mem [2**c16_mem_pkg::ROM_AW];
		c16_mem_pkg::byte_t q;

		always_ff @(posedge clk_sys) begin
			if (we_i && (bank_i == c16_mem_pkg::bank_e'(b)))
				mem[waddr_i] <= wdata_i;
			// Deselected or empty bank drives all ones
			q <= (bank_sel_i[b] && bank_ok[b]) ? mem[cpu_addr_i] : 8'hFF;
		end

		assign bank_q[b] = q;
	end

	// Combine the bank outputs
	always_comb begin
		rd_o = 8'hFF;
		for (int i = 0; i < c16_mem_pkg::NUM_BANKS; i++)
			rd_o = rd_o & bank_q[i];
	end

endmodule

`default_nettype wire

//--- verification/c16_memory_props.sv
`timescale 1ns/1ps
`default_nettype none

module c16_memory_props #(
	parameter int DL_FIFO_DEPTH = 4
) (
	input wire                             clk_sys,
	input wire                             reset,
	input wire                             push_i,
	input wire                             credit_i,
	input wire [$clog2(DL_FIFO_DEPTH):0]   count_i
);

	// Number of failed assertions
	int assert_fails = 0;

	// Host credits keep pushes away from a full buffer
	no_push_when_full: assert property (@(posedge clk_sys) disable iff (reset)
		push_i |-> (count_i < DL_FIFO_DEPTH))
	else begin
		assert_fails++;
		$error("push into a full download FIFO");
	end

	// One entry leaves the buffer for every credit pulse
	credit_on_pop: assert property (@(posedge clk_sys) disable iff (reset)
		1'b1 |=> (int'(count_i) ==
			int'($past(count_i)) + int'($past(push_i)) - int'($past(credit_i))))
	else begin
		assert_fails++;
		$error("credit pulse does not match a pop");
	end

	occupancy_bound: assert property (@(posedge clk_sys) disable iff (reset)
		count_i <= DL_FIFO_DEPTH)
	else begin
		assert_fails++;
		$error("download FIFO occupancy above its depth");
	end

endmodule

`default_nettype wire

//--- verification/tb_c16_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_c16_memory;

	localparam int DL_FIFO_DEPTH  = 4;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int PATCH_CYCLES   = 16;
	localparam logic [15:0] PRG_LOAD = 16'h1001;
	localparam int          PRG_LEN  = 40;
	// End address is the first byte past the program
	localparam logic [15:0] PRG_END  = PRG_LOAD + PRG_LEN;
	localparam logic [7:0]  PTR_ADDRS [8] = '{
		8'h2D, 8'h2E, 8'h2F, 8'h30, 8'h31, 8'h32, 8'h9D, 8'h9E
	};

	typedef enum {
		OP_RESET,
		OP_LOAD,
		OP_BANK_WR,
		OP_RAM_WR,
		OP_RD_RAM,
		OP_RD_CS0,
		OP_RD_CS1
	} op_e;
	typedef enum {EXP_LIT, EXP_RAM, EXP_BANK} exp_e;

	typedef struct {
		op_e                     op;
		c16_mem_pkg::load_kind_e kind;
		logic [2:0]              slot;
		c16_mem_pkg::bank_e      bank;
		logic [15:0]             addr;
		int                      count;
		exp_e                    src;
		c16_mem_pkg::byte_t      lit;
		logic                    flag;
	} step_t;

	logic                          clk_sys;
	logic                          reset;
	logic                          plus4_i;
	logic                          dl_active_i;
	c16_mem_pkg::load_kind_e       dl_kind_i;
	logic                          dl_valid_i;
	logic [c16_mem_pkg::DL_AW-1:0] dl_addr_i;
	c16_mem_pkg::byte_t            dl_data_i;
	logic                          dl_credit_o;
	logic [15:0]                   cpu_addr_i;
	c16_mem_pkg::byte_t            cpu_dout_i;
	logic                          cpu_rnw_i;
	logic                          cs_ram_i;
	logic                          cs0_i;
	logic                          cs1_i;
	logic                          cs_io_i;
	c16_mem_pkg::byte_t            cpu_din_o;

	step_t              steps [$];
	c16_mem_pkg::byte_t ram_ref [2**16];
	c16_mem_pkg::byte_t rom_ref [c16_mem_pkg::NUM_BANKS][2**c16_mem_pkg::ROM_AW];
	logic [15:0]        lfsr;
	int                 credits;

	c16_memory_top #(
		.DL_FIFO_DEPTH(DL_FIFO_DEPTH)
	) dut0 (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.plus4_i     (plus4_i),
		.dl_active_i (dl_active_i),
		.dl_kind_i   (dl_kind_i),
		.dl_valid_i  (dl_valid_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.dl_credit_o (dl_credit_o),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_dout_i  (cpu_dout_i),
		.cpu_rnw_i   (cpu_rnw_i),
		.cs_ram_i    (cs_ram_i),
		.cs0_i       (cs0_i),
		.cs1_i       (cs1_i),
		.cs_io_i     (cs_io_i),
		.cpu_din_o   (cpu_din_o)
	);

	bind download_fifo c16_memory_props #(
		.DL_FIFO_DEPTH(DL_FIFO_DEPTH)
	) u_fifo_props (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.push_i   (push_i),
		.credit_i (credit_o),
		.count_i  (count)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// Host credit counter gains one per credit pulse
	always @(posedge clk_sys) begin
		if (dl_credit_o) begin
			credits = credits + 1;
			check_credits(credits, 0, DL_FIFO_DEPTH, "credit return");
		end
	end

	// Stop at the first FIFO property failure
	always @(posedge clk_sys) begin
		if (dut0.u_download_fifo.u_fifo_props.assert_fails != 0) begin
			$display("A download FIFO property failed");
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////
	// Checks and helpers
	////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_byte(input c16_mem_pkg::byte_t got, input c16_mem_pkg::byte_t expected,
		input string what);
		if (got !== expected) begin
			$display("CHECK FAILED at %0t ns: %s returned %02h, expected %02h",
				$time, what, got, expected);
			abort_run();
		end
	endtask

	task automatic check_credits(input int got, input int lo, input int hi, input string what);
		if (got < lo || got > hi) begin
			$display("CHECK FAILED at %0t ns: %s left %0d credits, allowed %0d to %0d",
				$time, what, got, lo, hi);
			abort_run();
		end
	endtask

	// Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic c16_mem_pkg::byte_t random_byte();
		c16_mem_pkg::byte_t b;
		b = '0;
		for (int k = 0; k < 8; k++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			b = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	task automatic add_ctrl(input op_e op, input logic [15:0] addr,
		input c16_mem_pkg::byte_t data, input logic flag);
		step_t s;
		s = '{op, c16_mem_pkg::LOAD_PRG, 3'd0, c16_mem_pkg::BANK_KERNAL, addr, 0, EXP_LIT,
			data, flag};
		steps.push_back(s);
	endtask

	task automatic add_load(input c16_mem_pkg::load_kind_e kind, input logic [2:0] slot,
		input c16_mem_pkg::bank_e bank, input logic [15:0] addr, input int count,
		input logic overlap);
		step_t s;
		s = '{OP_LOAD, kind, slot, bank, addr, count, EXP_LIT, 8'h00, overlap};
		steps.push_back(s);
	endtask

	task automatic add_read(input op_e op, input logic [15:0] addr, input int count,
		input exp_e src, input c16_mem_pkg::bank_e bank, input c16_mem_pkg::byte_t lit);
		step_t s;
		s = '{op, c16_mem_pkg::LOAD_PRG, 3'd0, bank, addr, count, src, lit, 1'b0};
		steps.push_back(s);
	endtask

	////////////////////////////////////////////////////////////
	// Bus tasks that start and end at a falling edge
	////////////////////////////////////////////////////////////

	task automatic apply_reset(input logic plus4);
		plus4_i = plus4;
		reset = 1'b1;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		credits = DL_FIFO_DEPTH;
	endtask

	task automatic wait_for_credit();
		int n;
		n = 0;
		while (credits == 0) begin
			@(negedge clk_sys);
			n++;
			if (n > TIMEOUT_CYCLES) begin
				$display("Timeout: no download credit came back in %0d cycles", TIMEOUT_CYCLES);
				abort_run();
			end
		end
	endtask

	task automatic wait_all_credits();
		int n;
		n = 0;
		while (credits != DL_FIFO_DEPTH) begin
			@(negedge clk_sys);
			n++;
			if (n > TIMEOUT_CYCLES) begin
				$display("Timeout: the FIFO did not drain in %0d cycles", TIMEOUT_CYCLES);
				abort_run();
			end
		end
	endtask

	task automatic push_byte(input logic [c16_mem_pkg::DL_AW-1:0] addr,
		input c16_mem_pkg::byte_t data);
		wait_for_credit();
		dl_valid_i = 1'b1;
		dl_addr_i = addr;
		dl_data_i = data;
		credits = credits - 1;
		@(negedge clk_sys);
		dl_valid_i = 1'b0;
	endtask

	task automatic load_image(input step_t s);
		c16_mem_pkg::byte_t            b;
		logic [c16_mem_pkg::DL_AW-1:0] off;
		dl_kind_i = s.kind;
		dl_active_i = 1'b1;
		if (s.kind == c16_mem_pkg::LOAD_PRG) begin
			// Two byte header with the load address
			push_byte(17'd0, s.addr[7:0]);
			push_byte(17'd1, s.addr[15:8]);
			for (int i = 0; i < s.count; i++) begin
				b = random_byte();
				ram_ref[s.addr + 16'(i)] = b;
				push_byte(17'(i + 2), b);
			end
		end else begin
			for (int i = 0; i < s.count; i++) begin
				b = random_byte();
				off = {s.slot, s.addr[13:0] + 14'(i)};
				rom_ref[int'(s.bank)][off[13:0]] = b;
				push_byte(off, b);
			end
		end
		wait_all_credits();
		dl_active_i = 1'b0;
		@(negedge clk_sys);
		// Pointer patch has a fixed length unless the next load overlaps it
		if (s.kind == c16_mem_pkg::LOAD_PRG && !s.flag)
			repeat (PATCH_CYCLES + 2) @(negedge clk_sys);
	endtask

	task automatic write_bank_reg(input logic [15:0] addr);
		cpu_addr_i = addr;
		cpu_rnw_i = 1'b0;
		cs_io_i = 1'b0;
		@(negedge clk_sys);
		cs_io_i = 1'b1;
		@(negedge clk_sys);
		cpu_rnw_i = 1'b1;
	endtask

	task automatic write_ram(input logic [15:0] addr, input c16_mem_pkg::byte_t data);
		cpu_addr_i = addr;
		cpu_dout_i = data;
		cpu_rnw_i = 1'b0;
		cs_ram_i = 1'b0;
		@(negedge clk_sys);
		cs_ram_i = 1'b1;
		// Held three cycles past the release
		repeat (3) @(negedge clk_sys);
		cpu_rnw_i = 1'b1;
		ram_ref[addr] = data;
	endtask

	task automatic read_and_compare(input step_t s);
		c16_mem_pkg::byte_t expected;
		logic [15:0]        a;
		for (int i = 0; i < s.count; i++) begin
			a = s.addr + 16'(i);
			cpu_addr_i = a;
			cpu_rnw_i = 1'b1;
			cs_ram_i = (s.op != OP_RD_RAM);
			cs0_i = (s.op != OP_RD_CS0);
			cs1_i = (s.op != OP_RD_CS1);
			@(posedge clk_sys);
			@(negedge clk_sys);
			case (s.src)
				EXP_LIT: expected = s.lit;
				EXP_RAM: expected = ram_ref[a];
				default: expected = rom_ref[int'(s.bank)][a[13:0]];
			endcase
			check_byte(cpu_din_o, expected, $sformatf("read at %04h", a));
		end
		cs_ram_i = 1'b1;
		cs0_i = 1'b1;
		cs1_i = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus table and main sequence
	////////////////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		plus4_i = 1'b0;
		dl_active_i = 1'b0;
		dl_kind_i = c16_mem_pkg::LOAD_PRG;
		dl_valid_i = 1'b0;
		dl_addr_i = '0;
		dl_data_i = '0;
		cpu_addr_i = '0;
		cpu_dout_i = '0;
		cpu_rnw_i = 1'b1;
		cs_ram_i = 1'b1;
		cs0_i = 1'b1;
		cs1_i = 1'b1;
		cs_io_i = 1'b1;
		lfsr = 16'd2077;
		credits = DL_FIFO_DEPTH;

		add_ctrl(OP_RESET, 16'h0000, 8'h00, 1'b0);
		// Firmware loads queue up behind the program patch
		add_load(c16_mem_pkg::LOAD_PRG, 3'd0, c16_mem_pkg::BANK_KERNAL, PRG_LOAD, PRG_LEN, 1'b1);
		add_load(c16_mem_pkg::LOAD_ROM, 3'd1, c16_mem_pkg::BANK_KERNAL, 16'h0000, 16, 1'b0);
		add_load(c16_mem_pkg::LOAD_ROM, 3'd1, c16_mem_pkg::BANK_KERNAL, 16'h3C00, 8, 1'b0);
		add_load(c16_mem_pkg::LOAD_ROM, 3'd2, c16_mem_pkg::BANK_BASIC, 16'h0000, 16, 1'b0);
		add_load(c16_mem_pkg::LOAD_ROM, 3'd3, c16_mem_pkg::BANK_FUNC_LO, 16'h0000, 16, 1'b0);
		add_load(c16_mem_pkg::LOAD_ROM, 3'd4, c16_mem_pkg::BANK_FUNC_HI, 16'h0000, 16, 1'b0);
		add_read(OP_RD_RAM, PRG_LOAD, PRG_LEN, EXP_RAM, c16_mem_pkg::BANK_KERNAL, 8'h00);
		for (int p = 0; p < 8; p++)
			add_read(OP_RD_RAM, {8'h00, PTR_ADDRS[p]}, 1, EXP_LIT, c16_mem_pkg::BANK_KERNAL,
				(p % 2 == 1) ? PRG_END[15:8] : PRG_END[7:0]);

		// Bank register clear
		add_read(OP_RD_CS0, 16'h8000, 16, EXP_BANK, c16_mem_pkg::BANK_BASIC, 8'h00);
		add_read(OP_RD_CS1, 16'hC000, 16, EXP_BANK, c16_mem_pkg::BANK_KERNAL, 8'h00);
		// Write ignored outside Plus/4 mode
		add_ctrl(OP_BANK_WR, 16'hFDD2, 8'h00, 1'b0);
		add_read(OP_RD_CS0, 16'h8000, 16, EXP_BANK, c16_mem_pkg::BANK_BASIC, 8'h00);

		add_ctrl(OP_RESET, 16'h0000, 8'h00, 1'b1);
		add_ctrl(OP_BANK_WR, 16'hFDD2, 8'h00, 1'b0);
		add_read(OP_RD_CS0, 16'h8000, 16, EXP_BANK, c16_mem_pkg::BANK_FUNC_LO, 8'h00);
		add_ctrl(OP_BANK_WR, 16'hFDD8, 8'h00, 1'b0);
		add_read(OP_RD_CS0, 16'h8000, 16, EXP_BANK, c16_mem_pkg::BANK_BASIC, 8'h00);
		add_read(OP_RD_CS1, 16'hC000, 16, EXP_BANK, c16_mem_pkg::BANK_FUNC_HI, 8'h00);
		add_read(OP_RD_CS1, 16'hFC00, 8, EXP_BANK, c16_mem_pkg::BANK_KERNAL, 8'h00);

		// Cartridge banks empty, loaded, then cleared by reset
		add_ctrl(OP_BANK_WR, 16'hFDD5, 8'h00, 1'b0);
		add_read(OP_RD_CS0, 16'h8000, 4, EXP_LIT, c16_mem_pkg::BANK_KERNAL, 8'hFF);
		add_read(OP_RD_CS1, 16'hC000, 4, EXP_LIT, c16_mem_pkg::BANK_KERNAL, 8'hFF);
		add_load(c16_mem_pkg::LOAD_CRT, 3'd0, c16_mem_pkg::BANK_CART_LO, 16'h0000, 16, 1'b0);
		add_load(c16_mem_pkg::LOAD_CRT, 3'd1, c16_mem_pkg::BANK_CART_HI, 16'h0000, 16, 1'b0);
		add_read(OP_RD_CS0, 16'h8000, 16, EXP_BANK, c16_mem_pkg::BANK_CART_LO, 8'h00);
		add_read(OP_RD_CS1, 16'hC000, 16, EXP_BANK, c16_mem_pkg::BANK_CART_HI, 8'h00);
		add_ctrl(OP_RESET, 16'h0000, 8'h00, 1'b1);
		add_ctrl(OP_BANK_WR, 16'hFDD5, 8'h00, 1'b0);
		add_read(OP_RD_CS0, 16'h8000, 4, EXP_LIT, c16_mem_pkg::BANK_KERNAL, 8'hFF);
		add_read(OP_RD_CS1, 16'hC000, 4, EXP_LIT, c16_mem_pkg::BANK_KERNAL, 8'hFF);

		// CPU write and the program still in RAM after reset
		add_ctrl(OP_RAM_WR, 16'h2000, 8'hA5, 1'b0);
		add_read(OP_RD_RAM, 16'h2000, 1, EXP_RAM, c16_mem_pkg::BANK_KERNAL, 8'h00);
		add_read(OP_RD_RAM, PRG_LOAD, PRG_LEN, EXP_RAM, c16_mem_pkg::BANK_KERNAL, 8'h00);

		foreach (steps[i]) begin
			case (steps[i].op)
				OP_RESET:   apply_reset(steps[i].flag);
				OP_LOAD:    load_image(steps[i]);
				OP_BANK_WR: write_bank_reg(steps[i].addr);
				OP_RAM_WR:  write_ram(steps[i].addr, steps[i].lit);
				default:    read_and_compare(steps[i]);
			endcase
		end

		if (dut0.u_download_fifo.u_fifo_props.assert_fails == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("FIFO property failures: %0d",
				dut0.u_download_fifo.u_fifo_props.assert_fails);
			abort_run();
		end
	end

endmodule

`default_nettype wire
